// File: spi_pkg.sv
`default_nettype none

package spi_pkg;

  // bus word and serial byte.
  typedef logic [31:0] reg_word_t;
  typedef logic [7:0]  spi_byte_t;

  // control register fields.
  typedef logic [7:0] sel_t;
  typedef logic [7:0] conf_t;
  typedef logic [1:0] aux_t;

  // bit positions inside conf.
  localparam int CONF_CPOL_BIT = 0;
  localparam int CONF_CPHA_BIT = 1;

  // register addresses.
  localparam logic ADDR_DATA = 1'b0;
  localparam logic ADDR_CTRL = 1'b1;

  // control register layout.
  localparam int SEL_LSB         = 24;
  localparam int CONF_LSB        = 16;
  localparam int AUX_LSB         = 8;
  localparam int STAT_WP_BIT     = 2;
  localparam int STAT_TX_RDY_BIT = 1;
  localparam int STAT_RX_RDY_BIT = 0;

  typedef enum logic [1:0] {
    XFER_IDLE,
    XFER_BUSY,
    XFER_COMPLETE,
    XFER_RELEASE
  } xfer_state_t;

  typedef enum logic [1:0] {
    XCVR_IDLE,
    XCVR_LEAD,
    XCVR_TRAIL,
    XCVR_DONE
  } xcvr_state_t;

endpackage

`default_nettype wire

// File: spi_sclk_timer.sv
`timescale 1ns/10ps
`default_nettype none

module spi_sclk_timer #(
  parameter int CLK_FREQ  = 10_000_000,
  parameter int SPI_SPEED = 1_000_000
) (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic run,
  output logic      half_tick
);

  // clk cycles per half sclk period, never below one.
  localparam int HALF_RAW = CLK_FREQ / (2 * SPI_SPEED);
  localparam int HALF_CNT = (HALF_RAW > 1) ? HALF_RAW : 1;
  localparam int CNT_W    = (HALF_CNT > 1) ? $clog2(HALF_CNT) : 1;

  localparam logic [CNT_W-1:0] RELOAD = CNT_W'(HALF_CNT - 1);

  logic [CNT_W-1:0] count_q;

  // counter sits at the reload value while stopped.
  // so the first half period is as long as the rest.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= RELOAD;
    end else if (!run) begin
      count_q <= RELOAD;
    end else if (count_q == '0) begin
      count_q <= RELOAD;
    end else begin
      count_q <= count_q - 1'b1;
    end
  end

  assign half_tick = run && (count_q == '0);

  a_no_tick_stopped: assert property (@(posedge clk) disable iff (!rst_n)
    !run |-> !half_tick);

endmodule

`default_nettype wire

// File: spi_shift_reg.sv
`timescale 1ns/10ps
`default_nettype none

module spi_shift_reg (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               load,
  input  wire spi_pkg::spi_byte_t tx_byte,
  input  wire logic               sample,
  input  wire logic               shift,
  input  wire logic               miso,
  output logic                    mosi,
  output spi_pkg::spi_byte_t      rx_byte
);

  import spi_pkg::*;

  spi_byte_t shift_q;
  logic      sample_q;
  logic      in_bit;

  // a sample in the shift cycle goes straight in.
  assign in_bit = sample ? miso : sample_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shift_q <= '0;
    end else if (load) begin
      shift_q <= tx_byte;
    end else if (shift) begin
      shift_q <= {shift_q[$bits(spi_byte_t)-2:0], in_bit};
    end
  end

  // miso capture.
  always_ff @(posedge clk) begin
    if (sample) begin
      sample_q <= miso;
    end
  end

  // msb first on the wire.
  assign mosi    = shift_q[$bits(spi_byte_t)-1];
  assign rx_byte = shift_q;

  a_load_alone: assert property (@(posedge clk) disable iff (!rst_n)
    load |-> !(sample || shift));

endmodule

`default_nettype wire

// File: spi_xcvr.sv
`timescale 1ns/10ps
`default_nettype none

module spi_xcvr #(
  parameter int CLK_FREQ  = 10_000_000,
  parameter int SPI_SPEED = 1_000_000
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              start,
  input  wire spi_pkg::spi_byte_t tx_byte,
  input  wire spi_pkg::conf_t    conf,
  input  wire logic              miso,
  output logic                   done,
  output spi_pkg::spi_byte_t     rx_byte,
  output logic                   mosi,
  output logic                   sclk
);

  import spi_pkg::*;

  xcvr_state_t state_q;
  logic [2:0]  bit_cnt_q;
  logic        sclk_q;
  logic        cpol;
  logic        cpha;
  logic        run;
  logic        half_tick;
  logic        lead_edge;
  logic        trail_edge;
  logic        last_edge;
  logic        sample;
  logic        shift;

  assign cpol = conf[CONF_CPOL_BIT];
  assign cpha = conf[CONF_CPHA_BIT];

  assign run        = (state_q == XCVR_LEAD) || (state_q == XCVR_TRAIL);
  assign lead_edge  = half_tick && (state_q == XCVR_LEAD);
  assign trail_edge = half_tick && (state_q == XCVR_TRAIL);
  assign last_edge  = trail_edge && (bit_cnt_q == 3'd7);

  // cpha=1 keeps bit 7 on mosi through the first lead edge.
  // the final shift shares the cycle with the last sample.
  assign sample = cpha ? trail_edge : lead_edge;
  assign shift  = cpha ? ((lead_edge && bit_cnt_q != 3'd0) || last_edge) : trail_edge;
  assign done   = (state_q == XCVR_DONE);
  assign sclk   = sclk_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= XCVR_IDLE;
      bit_cnt_q <= '0;
    end else begin
      case (state_q)
        XCVR_IDLE: begin
          if (start) begin
            state_q   <= XCVR_LEAD;
            bit_cnt_q <= '0;
          end
        end
        XCVR_LEAD: begin
          if (half_tick) begin
            state_q <= XCVR_TRAIL;
          end
        end
        XCVR_TRAIL: begin
          if (half_tick) begin
            bit_cnt_q <= bit_cnt_q + 3'd1;
            state_q   <= last_edge ? XCVR_DONE : XCVR_LEAD;
          end
        end
        XCVR_DONE: state_q <= XCVR_IDLE;
        default:   state_q <= XCVR_IDLE;
      endcase
    end
  end

  // sclk parks at cpol outside a transfer.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sclk_q <= 1'b0;
    end else if (!run) begin
      sclk_q <= cpol;
    end else if (half_tick) begin
      sclk_q <= ~sclk_q;
    end
  end

  spi_sclk_timer #(
    .CLK_FREQ  (CLK_FREQ),
    .SPI_SPEED (SPI_SPEED)
  ) i_sclk_timer (
    .clk       (clk),
    .rst_n     (rst_n),
    .run       (run),
    .half_tick (half_tick)
  );

  spi_shift_reg i_shift_reg (
    .clk     (clk),
    .rst_n   (rst_n),
    .load    (start),
    .tx_byte (tx_byte),
    .sample  (sample),
    .shift   (shift),
    .miso    (miso),
    .mosi    (mosi),
    .rx_byte (rx_byte)
  );

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    done |=> !done);

  a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> state_q == XCVR_IDLE);

endmodule

`default_nettype wire

// File: spi_master.sv
`timescale 1ns/10ps
`default_nettype none

module spi_master #(
  parameter int CLK_FREQ  = 10_000_000,
  parameter int SPI_SPEED = 1_000_000
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              read,
  input  wire logic              write,
  input  wire logic              address,
  input  wire logic [3:0]        be,
  input  wire spi_pkg::reg_word_t data_in,
  output spi_pkg::reg_word_t     data_out,
  input  wire logic              miso,
  input  wire logic              wp_n,
  output logic                   mosi,
  output logic                   sclk,
  output spi_pkg::sel_t          selects,
  output spi_pkg::aux_t          aux
);

  import spi_pkg::*;

  xfer_state_t state_q;
  xfer_state_t state_d;
  conf_t       conf_q;
  spi_byte_t   rx_data_q;
  spi_byte_t   rx_byte;
  logic        start;
  logic        done;
  logic        wr_en;
  logic        rd_en;

  // a cycle with both strobes counts as neither.
  assign wr_en = write && !read;
  assign rd_en = read && !write;

  // control register, byte-lane writes.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      selects <= '1;
      conf_q  <= '0;
      aux     <= '0;
    end else if (wr_en && address == ADDR_CTRL) begin
      if (be[3]) begin
        selects <= data_in[SEL_LSB +: $bits(sel_t)];
      end
      if (be[2]) begin
        conf_q <= data_in[CONF_LSB +: $bits(conf_t)];
      end
      if (be[1]) begin
        aux <= data_in[AUX_LSB +: $bits(aux_t)];
      end
    end
  end

  // received byte, held until the next transfer ends.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_data_q <= '0;
    end else if (done && state_q == XFER_BUSY) begin
      rx_data_q <= rx_byte;
    end
  end

  // transfer FSM.
  always_comb begin
    state_d = state_q;
    start   = 1'b0;
    case (state_q)
      XFER_IDLE: begin
        if (wr_en && address == ADDR_DATA && be[0]) begin
          start   = 1'b1;
          state_d = XFER_BUSY;
        end
      end
      XFER_BUSY: begin
        if (done) begin
          state_d = XFER_COMPLETE;
        end
      end
      XFER_COMPLETE: begin
        // rx ready clears only through a data read.
        if (rd_en && address == ADDR_DATA) begin
          state_d = XFER_RELEASE;
        end
      end
      XFER_RELEASE: begin
        if (!read && !write) begin
          state_d = XFER_IDLE;
        end
      end
      default: state_d = XFER_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= XFER_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // read mux with status bits.
  always_comb begin
    data_out = '0;
    if (rd_en) begin
      if (address == ADDR_DATA) begin
        data_out[$bits(spi_byte_t)-1:0] = rx_data_q;
      end else begin
        data_out[SEL_LSB +: $bits(sel_t)]   = selects;
        data_out[CONF_LSB +: $bits(conf_t)] = conf_q;
        data_out[AUX_LSB +: $bits(aux_t)]   = aux;
        data_out[STAT_WP_BIT]               = ~wp_n;
        data_out[STAT_TX_RDY_BIT]           = (state_q != XFER_BUSY);
        data_out[STAT_RX_RDY_BIT]           = (state_q == XFER_COMPLETE);
      end
    end
  end

  // tx byte goes straight to the shift register on start.
  spi_xcvr #(
    .CLK_FREQ  (CLK_FREQ),
    .SPI_SPEED (SPI_SPEED)
  ) i_xcvr (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .tx_byte (data_in[$bits(spi_byte_t)-1:0]),
    .conf    (conf_q),
    .miso    (miso),
    .done    (done),
    .rx_byte (rx_byte),
    .mosi    (mosi),
    .sclk    (sclk)
  );

  a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> state_q == XFER_IDLE);

  // the transceiver must finish within the busy window.
  a_done_busy: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> state_q == XFER_BUSY);

endmodule

`default_nettype wire

// File: spi_periph_top.sv
`timescale 1ns/10ps
`default_nettype none

module spi_periph_top #(
  parameter int CLK_FREQ  = 10_000_000,
  parameter int SPI_SPEED = 1_000_000
) (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               read,
  input  wire logic               write,
  input  wire logic               address,
  input  wire logic [3:0]         be,
  input  wire spi_pkg::reg_word_t data_in,
  output wire spi_pkg::reg_word_t data_out,
  input  wire logic               miso,
  input  wire logic               wp_n,
  output wire logic               mosi,
  output wire logic               sclk,
  output wire spi_pkg::sel_t      selects,
  output wire spi_pkg::aux_t      aux
);

  spi_master #(
    .CLK_FREQ  (CLK_FREQ),
    .SPI_SPEED (SPI_SPEED)
  ) i_master (
    .clk      (clk),
    .rst_n    (rst_n),
    .read     (read),
    .write    (write),
    .address  (address),
    .be       (be),
    .data_in  (data_in),
    .data_out (data_out),
    .miso     (miso),
    .wp_n     (wp_n),
    .mosi     (mosi),
    .sclk     (sclk),
    .selects  (selects),
    .aux      (aux)
  );

endmodule

`default_nettype wire

// File: tb_spi_slave.sv
`timescale 1ns/10ps
`default_nettype none

module tb_spi_slave (
  input  wire logic               sclk,
  input  wire logic               mosi,
  input  wire logic               ss_n,
  input  wire spi_pkg::conf_t     conf,
  input  wire spi_pkg::spi_byte_t resp_byte,
  output logic                    miso,
  output spi_pkg::spi_byte_t      captured
);

  import spi_pkg::*;

  spi_byte_t tx_q;
  logic      cpol;
  logic      cpha;
  wire logic mosi_late;

  assign cpol = conf[CONF_CPOL_BIT];
  assign cpha = conf[CONF_CPHA_BIT];

  // mosi as it was just before the sclk edge.
  assign #1 mosi_late = mosi;

  initial begin
    miso     = 1'b0;
    tx_q     = '0;
    captured = '0;
  end

  // a falling select frames a new byte.
  always @(negedge ss_n) begin
    tx_q     = resp_byte;
    captured = '0;
    if (!cpha) begin
      miso = resp_byte[7];
    end
  end

  // lead edge leaves the rest level, trail edge returns to it.
  always @(sclk) begin
    if (ss_n === 1'b0) begin
      if ((sclk !== cpol) ^ cpha) begin
        captured = {captured[6:0], mosi_late};
      end else if (cpha) begin
        miso = tx_q[7];
        tx_q = tx_q << 1;
      end else begin
        tx_q = tx_q << 1;
        miso = tx_q[7];
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_spi_periph.sv
`timescale 1ns/10ps
`default_nettype none

module tb_spi_periph;

  import spi_pkg::*;

  localparam int TIMEOUT_CYCLES = 200;

  logic       clk;
  logic       rst_n;
  logic       read;
  logic       write;
  logic       address;
  logic [3:0] be;
  reg_word_t  data_in;
  reg_word_t  data_out;
  logic       wp_n;
  wire logic  miso;
  wire logic  mosi;
  wire logic  sclk;
  sel_t       selects;
  aux_t       aux;

  // model state.
  sel_t       sel_m;
  conf_t      conf_m;
  aux_t       aux_m;
  spi_byte_t  resp_byte;
  spi_byte_t  captured;
  integer     seed;

  spi_periph_top i_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .read     (read),
    .write    (write),
    .address  (address),
    .be       (be),
    .data_in  (data_in),
    .data_out (data_out),
    .miso     (miso),
    .wp_n     (wp_n),
    .mosi     (mosi),
    .sclk     (sclk),
    .selects  (selects),
    .aux      (aux)
  );

  tb_spi_slave i_slave (
    .sclk      (sclk),
    .mosi      (mosi),
    .ss_n      (selects[0]),
    .conf      (conf_m),
    .resp_byte (resp_byte),
    .miso      (miso),
    .captured  (captured)
  );

  always #50 clk = ~clk;

  task automatic check_value(input string name, input reg_word_t expected,
                             input reg_word_t actual);
    assert (actual === expected) else begin
      $display("Mismatch at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic bus_write(input logic addr, input logic [3:0] be_v, input reg_word_t word);
    @(posedge clk);
    #5;
    write   = 1'b1;
    address = addr;
    be      = be_v;
    data_in = word;
    @(posedge clk);
    #5;
    write = 1'b0;
  endtask

  // data_out is sampled mid-cycle.
  task automatic bus_read(input logic addr, output reg_word_t word);
    @(posedge clk);
    #5;
    read    = 1'b1;
    address = addr;
    @(negedge clk);
    word = data_out;
    @(posedge clk);
    #5;
    read = 1'b0;
  endtask

  task automatic write_ctrl(input logic [3:0] be_v, input reg_word_t word);
    sel_m  = be_v[3] ? word[31:24] : sel_m;
    conf_m = be_v[2] ? word[23:16] : conf_m;
    aux_m  = be_v[1] ? word[9:8] : aux_m;
    bus_write(ADDR_CTRL, be_v, word);
  endtask

  function automatic reg_word_t ctrl_word(input logic tx_rdy, input logic rx_rdy);
    return {sel_m, conf_m, 6'b0, aux_m, 5'b0, ~wp_n, tx_rdy, rx_rdy};
  endfunction

  task automatic wait_rx_ready();
    reg_word_t word;
    int        waited;
    word   = '0;
    waited = 0;
    while (word[0] !== 1'b1 && waited < TIMEOUT_CYCLES) begin
      bus_read(ADDR_CTRL, word);
      waited += 2;
    end
    assert (word[0] === 1'b1) else begin
      $display("Receive-ready did not rise within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $fatal(1);
    end
    check_value("ctrl", ctrl_word(1'b1, 1'b1), word);
  endtask

  task automatic run_transfer(input logic [1:0] mode, input logic overwrite);
    spi_byte_t tx;
    reg_word_t word;
    tx        = $random(seed);
    resp_byte = $random(seed);
    word      = $random(seed);
    write_ctrl(4'b1100, {8'hFF, word[7:2], mode, 16'h0});
    write_ctrl(4'b1000, {8'hFE, 24'h0});
    check_value("sclk", mode[0], sclk);
    word      = $random(seed);
    word[7:0] = tx;
    bus_write(ADDR_DATA, 4'b0001, word);
    bus_read(ADDR_CTRL, word);
    check_value("ctrl", ctrl_word(1'b0, 1'b0), word);
    // busy, so this byte must be dropped.
    if (overwrite) begin
      bus_write(ADDR_DATA, 4'b0001, {24'h0, ~tx});
      bus_read(ADDR_CTRL, word);
      check_value("ctrl", ctrl_word(1'b0, 1'b0), word);
    end
    wait_rx_ready();
    check_value("slave captured", tx, captured);
    repeat (2) begin
      bus_read(ADDR_CTRL, word);
      check_value("ctrl", ctrl_word(1'b1, 1'b1), word);
    end
    bus_read(ADDR_DATA, word);
    check_value("data_out", {24'h0, resp_byte}, word);
    bus_read(ADDR_CTRL, word);
    check_value("ctrl", ctrl_word(1'b1, 1'b0), word);
    check_value("sclk", mode[0], sclk);
    write_ctrl(4'b1000, {8'hFF, 24'h0});
  endtask

  initial begin
    reg_word_t  word;
    logic [3:0] be_v;
    clk       = 1'b0;
    rst_n     = 1'b0;
    read      = 1'b0;
    write     = 1'b0;
    address   = 1'b0;
    be        = '0;
    data_in   = '0;
    wp_n      = 1'b1;
    seed      = 5305;
    sel_m     = '1;
    conf_m    = '0;
    aux_m     = '0;
    resp_byte = '0;
    repeat (10) @(posedge clk);
    #5;
    rst_n = 1'b1;

    bus_read(ADDR_CTRL, word);
    check_value("ctrl", ctrl_word(1'b1, 1'b0), word);
    check_value("sclk", 1'b0, sclk);
    check_value("selects", sel_m, selects);

    // random control writes, only enabled lanes change.
    repeat (20) begin
      be_v = $random(seed);
      word = $random(seed);
      write_ctrl(be_v, word);
      wp_n = $random(seed);
      bus_read(ADDR_CTRL, word);
      check_value("ctrl", ctrl_word(1'b1, 1'b0), word);
      check_value("selects", sel_m, selects);
      check_value("aux", aux_m, aux);
    end

    for (int m = 0; m < 4; m++) begin
      run_transfer(m[1:0], 1'b0);
      run_transfer(m[1:0], 1'b1);
    end

    // no byte lane 0, no transfer.
    bus_write(ADDR_DATA, 4'b1110, {24'h0, 8'hA5});
    repeat (100) begin
      @(negedge clk);
      check_value("sclk", conf_m[0], sclk);
    end
    bus_read(ADDR_CTRL, word);
    check_value("ctrl", ctrl_word(1'b1, 1'b0), word);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
spi_pkg.sv
spi_sclk_timer.sv
spi_shift_reg.sv
spi_xcvr.sv
spi_master.sv
spi_periph_top.sv
tb_spi_slave.sv
tb_spi_periph.sv
